// File: hdl/async_fifo_pkg.sv
`default_nettype none

package async_fifo_pkg;

   localparam int WORD_W = 16;

   // widest pointer the gray helpers accept
   localparam int PTR_MAX_W = 16;

   typedef logic [WORD_W-1:0]    word_t;
   typedef logic [PTR_MAX_W-1:0] ptr_max_t;

   // flag pair as seen from one clock domain
   typedef struct packed {
      logic empty;
      logic full;
   } fifo_flags_t;

   function automatic ptr_max_t bin2gray(input ptr_max_t bin);
      return bin ^ (bin >> 1);
   endfunction

   // prefix xor from the msb down, zero extension leaves it unchanged
   function automatic ptr_max_t gray2bin(input ptr_max_t gray);
      ptr_max_t bin;
      bin[PTR_MAX_W-1] = gray[PTR_MAX_W-1];
      for (int i = PTR_MAX_W - 2; i >= 0; i--) begin
         bin[i] = bin[i+1] ^ gray[i];
      end
      return bin;
   endfunction

endpackage

`default_nettype wire

// File: hdl/afifo_wr_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module afifo_wr_ctrl
   import async_fifo_pkg::*;
#(
   parameter int ADDR_W = 3
) (
   input  logic              w_clk_i,
   input  logic              arst_n_i,
   input  logic              w_en_i,
   input  logic [ADDR_W:0]   rd_ptr_gray_i,
   output logic [ADDR_W:0]   wr_ptr_gray_o,
   output logic              mem_we_o,
   output logic [ADDR_W-1:0] mem_waddr_o,
   output logic [ADDR_W:0]   w_level_o,
   output fifo_flags_t       w_flags_o
);

   localparam int PTR_W = ADDR_W + 1;
   localparam logic [ADDR_W:0] DEPTH = {1'b1, {ADDR_W{1'b0}}};

   logic [ADDR_W:0] wr_bin_q;
   logic [ADDR_W:0] wr_bin_nxt;
   logic [ADDR_W:0] wr_gray_q;
   logic [ADDR_W:0] wr_gray_nxt;
   logic [ADDR_W:0] rd_gray_meta_q;
   logic [ADDR_W:0] rd_gray_sync_q;
   logic [ADDR_W:0] rd_bin_sync;
   logic [ADDR_W:0] level_q;
   logic [ADDR_W:0] level_nxt;
   fifo_flags_t     flags_q;
   logic            we;

   // a write while full is dropped here
   assign we = w_en_i & ~flags_q.full;

   assign wr_bin_nxt  = wr_bin_q + PTR_W'(we);
   assign wr_gray_nxt = PTR_W'(bin2gray(ptr_max_t'(wr_bin_nxt)));

   // read pointer as last seen through the synchronizer
   assign rd_bin_sync = PTR_W'(gray2bin(ptr_max_t'(rd_gray_sync_q)));

   // level follows the write in the same edge
   assign level_nxt = wr_bin_nxt - rd_bin_sync;

   always_ff @(posedge w_clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         wr_bin_q  <= '0;
         wr_gray_q <= '0;
      end else begin
         wr_bin_q  <= wr_bin_nxt;
         wr_gray_q <= wr_gray_nxt;
      end
   end

   // two flop chain for the read pointer
   always_ff @(posedge w_clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         rd_gray_meta_q <= '0;
         rd_gray_sync_q <= '0;
      end else begin
         rd_gray_meta_q <= rd_ptr_gray_i;
         rd_gray_sync_q <= rd_gray_meta_q;
      end
   end

   always_ff @(posedge w_clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         level_q       <= '0;
         flags_q.empty <= 1'b1;
         flags_q.full  <= 1'b0;
      end else begin
         level_q       <= level_nxt;
         flags_q.empty <= (level_nxt == '0);
         flags_q.full  <= (level_nxt == DEPTH);
      end
   end

   assign wr_ptr_gray_o = wr_gray_q;
   assign mem_we_o      = we;
   assign mem_waddr_o   = wr_bin_q[ADDR_W-1:0];
   assign w_level_o     = level_q;
   assign w_flags_o     = flags_q;

endmodule

`default_nettype wire

// File: hdl/afifo_rd_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module afifo_rd_ctrl
   import async_fifo_pkg::*;
#(
   parameter int ADDR_W = 3
) (
   input  logic              r_clk_i,
   input  logic              arst_n_i,
   input  logic              r_en_i,
   input  logic [ADDR_W:0]   wr_ptr_gray_i,
   output logic [ADDR_W:0]   rd_ptr_gray_o,
   output logic              mem_re_o,
   output logic [ADDR_W-1:0] mem_raddr_o,
   output logic [ADDR_W:0]   r_level_o,
   output fifo_flags_t       r_flags_o
);

   localparam int PTR_W = ADDR_W + 1;
   localparam logic [ADDR_W:0] DEPTH = {1'b1, {ADDR_W{1'b0}}};

   logic [ADDR_W:0] rd_bin_q;
   logic [ADDR_W:0] rd_bin_nxt;
   logic [ADDR_W:0] rd_gray_q;
   logic [ADDR_W:0] rd_gray_nxt;
   logic [ADDR_W:0] wr_gray_meta_q;
   logic [ADDR_W:0] wr_gray_sync_q;
   logic [ADDR_W:0] wr_bin_sync;
   logic [ADDR_W:0] level_q;
   logic [ADDR_W:0] level_nxt;
   fifo_flags_t     flags_q;
   logic            re;

   // reads while empty are ignored
   assign re = r_en_i & ~flags_q.empty;

   assign rd_bin_nxt  = rd_bin_q + PTR_W'(re);
   assign rd_gray_nxt = PTR_W'(bin2gray(ptr_max_t'(rd_bin_nxt)));

   assign wr_bin_sync = PTR_W'(gray2bin(ptr_max_t'(wr_gray_sync_q)));

   // words still to be read, counting the one leaving at this edge
   assign level_nxt = wr_bin_sync - rd_bin_nxt;

   always_ff @(posedge r_clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         rd_bin_q  <= '0;
         rd_gray_q <= '0;
      end else begin
         rd_bin_q  <= rd_bin_nxt;
         rd_gray_q <= rd_gray_nxt;
      end
   end

   // write pointer enters the read domain here
   always_ff @(posedge r_clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         wr_gray_meta_q <= '0;
         wr_gray_sync_q <= '0;
      end else begin
         wr_gray_meta_q <= wr_ptr_gray_i;
         wr_gray_sync_q <= wr_gray_meta_q;
      end
   end

   always_ff @(posedge r_clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         level_q       <= '0;
         flags_q.empty <= 1'b1;
         flags_q.full  <= 1'b0;
      end else begin
         level_q       <= level_nxt;
         flags_q.empty <= (level_nxt == '0);
         flags_q.full  <= (level_nxt == DEPTH);
      end
   end

   assign rd_ptr_gray_o = rd_gray_q;
   assign mem_re_o      = re;
   assign mem_raddr_o   = rd_bin_q[ADDR_W-1:0];
   assign r_level_o     = level_q;
   assign r_flags_o     = flags_q;

endmodule

`default_nettype wire

// File: hdl/afifo_mem.sv
`timescale 1ns/10ps
`default_nettype none

module afifo_mem
   import async_fifo_pkg::*;
#(
   parameter int ADDR_W = 3
) (
   input  logic              w_clk_i,
   input  logic              r_clk_i,
   input  logic              arst_n_i,
   input  logic              mem_we_i,
   input  logic [ADDR_W-1:0] mem_waddr_i,
   input  word_t             mem_wdata_i,
   input  logic              mem_re_i,
   input  logic [ADDR_W-1:0] mem_raddr_i,
   output word_t             r_data_o
);

   localparam int DEPTH = 2 ** ADDR_W;

   word_t mem_q [DEPTH];
   word_t r_data_q;

   // write port, w_clk_i domain
   always_ff @(posedge w_clk_i) begin
      if (mem_we_i) begin
         mem_q[mem_waddr_i] <= mem_wdata_i;
      end
   end

   // read port holds its word until the next read
   always_ff @(posedge r_clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         r_data_q <= '0;
      end else if (mem_re_i) begin
         r_data_q <= mem_q[mem_raddr_i];
      end
   end

   assign r_data_o = r_data_q;

endmodule

`default_nettype wire

// File: hdl/async_fifo.sv
`timescale 1ns/10ps
`default_nettype none

module async_fifo
   import async_fifo_pkg::*;
#(
   parameter int ADDR_W = 3
) (
   input  logic            w_clk_i,
   input  logic            r_clk_i,
   input  logic            arst_n_i,

   // write side
   input  logic            w_en_i,
   input  word_t           w_data_i,
   output logic [ADDR_W:0] w_level_o,
   output fifo_flags_t     w_flags_o,

   // read side
   input  logic            r_en_i,
   output word_t           r_data_o,
   output logic [ADDR_W:0] r_level_o,
   output fifo_flags_t     r_flags_o
);

   // gray pointers crossing between the domains
   logic [ADDR_W:0]   wr_ptr_gray;
   logic [ADDR_W:0]   rd_ptr_gray;

   logic              mem_we;
   logic [ADDR_W-1:0] mem_waddr;
   logic              mem_re;
   logic [ADDR_W-1:0] mem_raddr;

   afifo_wr_ctrl #(
      .ADDR_W(ADDR_W)
   ) u_wr_ctrl (
      .w_clk_i      (w_clk_i),
      .arst_n_i     (arst_n_i),
      .w_en_i       (w_en_i),
      .rd_ptr_gray_i(rd_ptr_gray),
      .wr_ptr_gray_o(wr_ptr_gray),
      .mem_we_o     (mem_we),
      .mem_waddr_o  (mem_waddr),
      .w_level_o    (w_level_o),
      .w_flags_o    (w_flags_o)
   );

   afifo_rd_ctrl #(
      .ADDR_W(ADDR_W)
   ) u_rd_ctrl (
      .r_clk_i      (r_clk_i),
      .arst_n_i     (arst_n_i),
      .r_en_i       (r_en_i),
      .wr_ptr_gray_i(wr_ptr_gray),
      .rd_ptr_gray_o(rd_ptr_gray),
      .mem_re_o     (mem_re),
      .mem_raddr_o  (mem_raddr),
      .r_level_o    (r_level_o),
      .r_flags_o    (r_flags_o)
   );

   // write data goes straight from the port into the array
   afifo_mem #(
      .ADDR_W(ADDR_W)
   ) u_mem (
      .w_clk_i    (w_clk_i),
      .r_clk_i    (r_clk_i),
      .arst_n_i   (arst_n_i),
      .mem_we_i   (mem_we),
      .mem_waddr_i(mem_waddr),
      .mem_wdata_i(w_data_i),
      .mem_re_i   (mem_re),
      .mem_raddr_i(mem_raddr),
      .r_data_o   (r_data_o)
   );

endmodule

`default_nettype wire

// File: testbench/tb_async_fifo.sv
`timescale 1ns/10ps
`default_nettype none

module tb_async_fifo
   import async_fifo_pkg::*;
;

   localparam int ADDR_W = 4;
   localparam logic [ADDR_W:0] LEVEL_FULL = 5'd16;
   localparam int WAIT_LIMIT = 200;

   logic            w_clk_i;
   logic            r_clk_i;
   logic            arst_n_i;
   logic            w_en_i;
   word_t           w_data_i;
   logic [ADDR_W:0] w_level_o;
   fifo_flags_t     w_flags_o;
   logic            r_en_i;
   word_t           r_data_o;
   logic [ADDR_W:0] r_level_o;
   fifo_flags_t     r_flags_o;

   logic [15:0] lfsr_state;
   word_t       ref_q[$];
   word_t       dropped_q[$];
   logic        rd_pending;
   word_t       rd_expect;
   logic        mon_en;

   async_fifo #(
      .ADDR_W(ADDR_W)
   ) dut (
      .w_clk_i  (w_clk_i),
      .r_clk_i  (r_clk_i),
      .arst_n_i (arst_n_i),
      .w_en_i   (w_en_i),
      .w_data_i (w_data_i),
      .w_level_o(w_level_o),
      .w_flags_o(w_flags_o),
      .r_en_i   (r_en_i),
      .r_data_o (r_data_o),
      .r_level_o(r_level_o),
      .r_flags_o(r_flags_o)
   );

   initial begin
      w_clk_i = 1'b0;
      forever #20 w_clk_i = ~w_clk_i;
   end

   // read clock offset so its edges never meet the write clock edges
   initial begin
      r_clk_i = 1'b0;
      #17;
      forever #20 r_clk_i = ~r_clk_i;
   end

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("Result: FAILED");
      $fatal(1);
   endtask

   task automatic expect_equal(input string name, input logic [15:0] exp,
                               input logic [15:0] act);
      assert (act == exp) else
         abort_run($sformatf("[ERROR] %s expected %h got %h", name, exp, act));
   endtask

   // galois lfsr with taps for x^16 + x^14 + x^13 + x^11 + 1
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      if (s[0]) begin
         return (s >> 1) ^ 16'hB400;
      end
      return s >> 1;
   endfunction

   function automatic logic [15:0] random_bits(input int n);
      logic [15:0] r;
      r = '0;
      for (int i = 0; i < n; i++) begin
         r = {r[14:0], lfsr_state[0]};
         lfsr_state = lfsr_next(lfsr_state);
      end
      return r;
   endfunction

   // full flag as seen 2 ns after the edge holds for the coming edge
   task automatic write_cycle(input logic en, input word_t data, output logic accepted);
      @(posedge w_clk_i);
      #2;
      accepted = en && !w_flags_o.full;
      w_en_i   = en;
      w_data_i = data;
      if (accepted) begin
         ref_q.push_back(data);
      end
   endtask

   // checks the word of the previous accepted read, then drives the next one
   task automatic read_cycle(input logic en);
      logic accepted;
      @(posedge r_clk_i);
      #2;
      if (rd_pending) begin
         foreach (dropped_q[i]) begin
            assert (r_data_o != dropped_q[i]) else
               abort_run($sformatf("[ERROR] r_data_o returned dropped word %h", r_data_o));
         end
         expect_equal("r_data_o", rd_expect, r_data_o);
      end
      rd_pending = 1'b0;
      accepted   = en && !r_flags_o.empty;
      r_en_i     = en;
      if (accepted) begin
         assert (ref_q.size() > 0) else
            abort_run("read accepted while the reference queue was empty");
         rd_expect  = ref_q.pop_front();
         rd_pending = 1'b1;
      end
   endtask

   task automatic check_idle_state();
      expect_equal("w_flags_o.empty", 16'd1, 16'(w_flags_o.empty));
      expect_equal("w_flags_o.full", 16'd0, 16'(w_flags_o.full));
      expect_equal("r_flags_o.empty", 16'd1, 16'(r_flags_o.empty));
      expect_equal("r_flags_o.full", 16'd0, 16'(r_flags_o.full));
      expect_equal("w_level_o", 16'd0, 16'(w_level_o));
      expect_equal("r_level_o", 16'd0, 16'(r_level_o));
      expect_equal("r_data_o", 16'd0, r_data_o);
   endtask

   task automatic write_random(input int n, input logic heavy);
      logic en;
      logic acc;
      for (int i = 0; i < n; i++) begin
         en = heavy ? (random_bits(2) != 16'd0) : (random_bits(1) != 16'd0);
         write_cycle(en, random_bits(15), acc);
      end
      write_cycle(1'b0, '0, acc);
   endtask

   task automatic read_random(input int n, input logic heavy);
      logic en;
      for (int i = 0; i < n; i++) begin
         en = heavy ? (random_bits(2) != 16'd0) : (random_bits(1) != 16'd0);
         read_cycle(en);
      end
      read_cycle(1'b0);
   endtask

   task automatic settle_and_check();
      logic [ADDR_W:0] last_w;
      logic [ADDR_W:0] last_r;
      int stable;
      int cycles;
      stable = 0;
      cycles = 0;
      last_w = w_level_o;
      last_r = r_level_o;
      while (stable < 8) begin
         @(posedge w_clk_i);
         #2;
         stable = (w_level_o == last_w && r_level_o == last_r) ? stable + 1 : 0;
         last_w = w_level_o;
         last_r = r_level_o;
         cycles++;
         if (cycles > WAIT_LIMIT) begin
            abort_run("timeout waiting for the fill levels to settle");
         end
      end
      expect_equal("w_level_o", 16'(ref_q.size()), 16'(w_level_o));
      expect_equal("r_level_o", 16'(ref_q.size()), 16'(r_level_o));
   endtask

   task automatic fill_until_full();
      logic acc;
      int cycles;
      cycles = 0;
      acc    = 1'b1;
      while (acc) begin
         write_cycle(1'b1, random_bits(15), acc);
         cycles++;
         if (cycles > WAIT_LIMIT) begin
            abort_run("timeout waiting for w_flags_o.full to rise");
         end
      end
      expect_equal("w_level_o", 16'(LEVEL_FULL), 16'(w_level_o));
   endtask

   // marked words have bit 15 set and are never accepted
   task automatic write_while_full(input int n);
      word_t word;
      logic  acc;
      for (int i = 0; i < n; i++) begin
         word = 16'h8000 | random_bits(15);
         write_cycle(1'b1, word, acc);
         assert (!acc) else abort_run("write accepted while w_flags_o.full was high");
         expect_equal("w_level_o", 16'(LEVEL_FULL), 16'(w_level_o));
         dropped_q.push_back(word);
      end
      write_cycle(1'b0, '0, acc);
      expect_equal("w_level_o", 16'(LEVEL_FULL), 16'(w_level_o));
   endtask

   task automatic drain_all();
      int cycles;
      cycles = 0;
      while (ref_q.size() > 0) begin
         read_cycle(1'b1);
         cycles++;
         if (cycles > WAIT_LIMIT) begin
            abort_run("timeout while draining the FIFO");
         end
      end
      read_cycle(1'b0);
   endtask

   task automatic wait_empty();
      int cycles;
      cycles = 0;
      while (!r_flags_o.empty) begin
         @(posedge r_clk_i);
         #2;
         cycles++;
         if (cycles > WAIT_LIMIT) begin
            abort_run("timeout waiting for r_flags_o.empty to rise");
         end
      end
   endtask

   task automatic read_while_empty(input int n);
      word_t           held_data;
      logic [ADDR_W:0] held_level;
      held_data  = r_data_o;
      held_level = r_level_o;
      for (int i = 0; i < n; i++) begin
         read_cycle(1'b1);
         expect_equal("r_data_o", held_data, r_data_o);
         expect_equal("r_level_o", 16'(held_level), 16'(r_level_o));
      end
      read_cycle(1'b0);
      expect_equal("r_data_o", held_data, r_data_o);
   endtask

   // level and flag consistency sampled away from the active edges
   always @(negedge w_clk_i) begin
      if (mon_en) begin
         assert (w_level_o <= LEVEL_FULL) else
            abort_run($sformatf("[ERROR] w_level_o above depth, got %h", w_level_o));
         expect_equal("w_flags_o.full", 16'(w_level_o == LEVEL_FULL), 16'(w_flags_o.full));
         expect_equal("w_flags_o.empty", 16'(w_level_o == '0), 16'(w_flags_o.empty));
      end
   end

   always @(negedge r_clk_i) begin
      if (mon_en) begin
         expect_equal("r_flags_o.empty", 16'(r_level_o == '0), 16'(r_flags_o.empty));
         expect_equal("r_flags_o.full", 16'(r_level_o == LEVEL_FULL), 16'(r_flags_o.full));
      end
   end

   initial begin
      w_en_i     = 1'b0;
      w_data_i   = '0;
      r_en_i     = 1'b0;
      arst_n_i   = 1'b1;
      mon_en     = 1'b0;
      rd_pending = 1'b0;
      rd_expect  = '0;
      lfsr_state = 16'd60788;
      #1;
      arst_n_i = 1'b0;
      mon_en   = 1'b1;
      for (int i = 0; i < 16; i++) begin
         @(posedge w_clk_i);
         #2;
         if (i == 8) begin
            check_idle_state();
         end
      end
      arst_n_i = 1'b1;
      check_idle_state();
      @(posedge w_clk_i);
      #2;
      check_idle_state();

      // writer ahead first and reader ahead second
      fork
         write_random(300, 1'b1);
         read_random(300, 1'b0);
      join
      fork
         write_random(300, 1'b0);
         read_random(300, 1'b1);
      join
      settle_and_check();

      fill_until_full();
      write_while_full(6);
      drain_all();
      wait_empty();
      read_while_empty(6);
      settle_and_check();

      $display("Result: PASSED");
      $finish;
   end

endmodule

`default_nettype wire

// File: async_fifo.f
hdl/async_fifo_pkg.sv
hdl/afifo_wr_ctrl.sv
hdl/afifo_rd_ctrl.sv
hdl/afifo_mem.sv
hdl/async_fifo.sv
testbench/tb_async_fifo.sv

// File: run_sim.sh
#!/bin/sh
# builds the async FIFO testbench with Verilator and runs it
# the exit status is the one of the simulation

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
   --timescale 1ns/10ps \
   --top-module tb_async_fifo \
   -f async_fifo.f \
   && ./obj_dir/Vtb_async_fifo \
   || { echo "simulation did not pass"; exit 1; }

exit 0
